// ==== bench/rs_issue_stage_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_issue_stage_props
    import rs_pkg::*;
(
    input logic                                  clk,
    input logic                                  rst,
    input logic                                  dispatch_stall,
    input logic                                  issue_ready,
    input logic                                  issue_valid,
    input logic [num_stations*station_depth-1:0] slot_valid
);

    // a grant needs issue_ready, and the issue port shows it one edge later
    property no_issue_after_backpressure;
        @(posedge clk) disable iff (rst) !issue_ready |=> !issue_valid;
    endproperty

    // a stalled dispatch reaches no station so no slot fills on that edge
    property no_write_while_stalled;
        @(posedge clk) disable iff (rst)
            dispatch_stall |=> ((slot_valid & ~$past(slot_valid)) == '0);
    endproperty

    property quiet_in_reset;
        @(posedge clk) rst |=> !issue_valid;
    endproperty

    assert property (no_issue_after_backpressure)
        else $error("issue_valid one cycle after issue_ready was low");
    assert property (no_write_while_stalled)
        else $error("a station slot filled while dispatch_stall was high");
    assert property (quiet_in_reset)
        else $error("issue_valid high during reset");

endmodule

bind rs_issue_stage rs_issue_stage_props rs_issue_stage_props_inst (
    .clk            (clk),
    .rst            (rst),
    .dispatch_stall (dispatch_stall),
    .issue_ready    (issue_ready),
    .issue_valid    (issue_valid),
    .slot_valid     ({g_station[1].reservation_station_inst.slot_valid,
                      g_station[0].reservation_station_inst.slot_valid})
);

`default_nettype wire

// ==== bench/rs_issue_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_issue_stage_tb
    import rs_pkg::*;
();

    localparam int n_random = 60;
    localparam int n_total = 5 + 4 + n_random;
    localparam int cycle_limit = 20 * n_total + 200;
    localparam int n_tags = 1 << rob_tag_w;

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    fu_class_t dispatch_class;
    alu_op_t   dispatch_op;
    rob_tag_t  dispatch_dest;
    word_t     dispatch_src1;
    logic      dispatch_src1_ready;
    word_t     dispatch_src2;
    logic      dispatch_src2_ready;
    logic      cdb_valid;
    rob_tag_t  cdb_tag;
    word_t     cdb_value;
    logic      issue_ready;
    logic      dispatch_stall;
    logic      issue_valid;
    fu_class_t issue_class;
    alu_op_t   issue_op;
    rob_tag_t  issue_dest;
    word_t     issue_a;
    word_t     issue_b;

    // the reorder buffer model keeps one record per destination tag
    logic [n_tags-1:0] busy;
    logic [n_tags-1:0] in_flight;
    logic [n_tags-1:0] pending;
    rs_entry_t         rec [n_tags];
    fu_class_t         rec_class [n_tags];
    time               rec_time [n_tags];
    // every broadcast seen on the bus, in order
    rob_tag_t          log_tag [$];
    word_t             log_value [$];
    time               log_time [$];
    int                errors;
    int                accepted;
    int                issued;
    int                cycles = 0;
    logic              random_ready;
    logic              random_bcast;
    logic              rr_check;
    fu_class_t         rr_next;

    rs_issue_stage rs_issue_stage_inst (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // first set bit at or after start, wrapping around, or -1 when none is set
    function automatic int first_set_from(input logic [n_tags-1:0] set, input int start);
        int idx;
        for (int k = 0; k < n_tags; k++) begin
            idx = (start + k) % n_tags;
            if (set[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    // a ready source keeps its value, a waiting one takes the first broadcast
    // of its tag at or after the dispatch edge, and returns 0 when none came yet
    function automatic logic expected_operand(input operand_u src, input logic ready,
                                              input time since, output word_t value);
        value = src.value;
        if (ready) begin
            return 1'b1;
        end
        for (int i = 0; i < log_tag.size(); i++) begin
            if ((log_tag[i] == src.pending.tag) && (log_time[i] >= since)) begin
                value = log_value[i];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_op(input alu_op_t got, input alu_op_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: issue_op is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_class(input fu_class_t got, input fu_class_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: issue_class is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one clock edge of the reorder buffer model with inputs changing 1 ns after it
    task automatic tick();
        logic taken;
        @(posedge clk);
        taken = dispatch_valid && !dispatch_stall;
        if (taken) begin
            rec[dispatch_dest] = {dispatch_op, dispatch_dest, dispatch_src1, dispatch_src2,
                                  dispatch_src1_ready, dispatch_src2_ready};
            rec_class[dispatch_dest] = dispatch_class;
            rec_time[dispatch_dest] = $time;
            in_flight[dispatch_dest] = 1'b1;
            accepted++;
            // a waiting source now needs a broadcast after this edge
            if (!dispatch_src1_ready) begin
                pending[dispatch_src1[rob_tag_w-1:0]] = 1'b1;
            end
            if (!dispatch_src2_ready) begin
                pending[dispatch_src2[rob_tag_w-1:0]] = 1'b1;
            end
        end
        // a broadcast on the acceptance edge is folded in by the router
        if (cdb_valid) begin
            log_tag.push_back(cdb_tag);
            log_value.push_back(cdb_value);
            log_time.push_back($time);
            pending[cdb_tag] = 1'b0;
        end
        #1;
        if (taken) begin
            dispatch_valid = 1'b0;
        end
        cdb_valid = 1'b0;
        if (random_ready) begin
            issue_ready = ($urandom_range(3) != 0);
        end
        if (random_bcast && (pending != '0) && ($urandom_range(1) == 0)) begin
            cdb_valid = 1'b1;
            cdb_tag   = rob_tag_t'(first_set_from(pending, $urandom_range(n_tags - 1)));
            cdb_value = $urandom;
        end
    endtask

    // puts one instruction on the dispatch port under a free destination tag
    task automatic offer(input fu_class_t cls, input logic all_ready);
        int tag;
        tag = first_set_from(~busy, $urandom_range(n_tags - 1));
        while (tag < 0) begin
            tick();
            tag = first_set_from(~busy, $urandom_range(n_tags - 1));
        end
        busy[tag]           = 1'b1;
        dispatch_valid      = 1'b1;
        dispatch_class      = cls;
        dispatch_op         = alu_op_t'($urandom_range(11));
        dispatch_dest       = rob_tag_t'(tag);
        dispatch_src1_ready = all_ready || ($urandom_range(1) == 1);
        dispatch_src2_ready = all_ready || ($urandom_range(1) == 1);
        // a waiting source carries the producer tag in its low bits
        dispatch_src1 = dispatch_src1_ready ? word_t'($urandom) : word_t'($urandom_range(7));
        dispatch_src2 = dispatch_src2_ready ? word_t'($urandom) : word_t'($urandom_range(7));
        // now and then the producer broadcasts in the dispatch cycle itself
        if (random_bcast && !dispatch_src1_ready && ($urandom_range(3) == 0)) begin
            cdb_valid = 1'b1;
            cdb_tag   = dispatch_src1[rob_tag_w-1:0];
            cdb_value = $urandom;
        end
    endtask

    task automatic wait_taken();
        while (dispatch_valid) begin
            tick();
        end
    endtask

    task automatic drain();
        while (dispatch_valid || (busy != '0)) begin
            tick();
        end
    endtask

    // the issue port is compared on every edge where issue_valid was set
    always @(posedge clk) begin : compare
        word_t exp_a;
        word_t exp_b;
        logic  ok_a;
        logic  ok_b;
        if (!rst && issue_valid) begin
            issued++;
            if (!in_flight[issue_dest]) begin
                errors++;
                $display("tag %0d issued at %0t with no instruction in flight",
                         issue_dest, $time);
            end else begin
                ok_a = expected_operand(rec[issue_dest].src1, rec[issue_dest].src1_ready,
                                        rec_time[issue_dest], exp_a);
                ok_b = expected_operand(rec[issue_dest].src2, rec[issue_dest].src2_ready,
                                        rec_time[issue_dest], exp_b);
                if (!ok_a || !ok_b) begin
                    errors++;
                    $display("tag %0d issued at %0t before its source was broadcast",
                             issue_dest, $time);
                end
                check_word("issue_a", issue_a, exp_a);
                check_word("issue_b", issue_b, exp_b);
                check_op(issue_op, rec[issue_dest].op);
                check_class(issue_class, rec_class[issue_dest]);
                in_flight[issue_dest] = 1'b0;
                busy[issue_dest]      = 1'b0;
            end
            // with both stations busy the classes must take turns
            if (rr_check) begin
                check_class(issue_class, rr_next);
                rr_next = ~rr_next;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        int hold;
        void'($urandom(32'h3fad_962c));
        rst                 = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_class      = 1'b0;
        dispatch_op         = op_add;
        dispatch_dest       = '0;
        dispatch_src1       = '0;
        dispatch_src1_ready = 1'b1;
        dispatch_src2       = '0;
        dispatch_src2_ready = 1'b1;
        cdb_valid           = 1'b0;
        cdb_tag             = '0;
        cdb_value           = '0;
        issue_ready         = 1'b0;
        busy                = '0;
        in_flight           = '0;
        pending             = '0;
        errors              = 0;
        accepted            = 0;
        issued              = 0;
        random_ready        = 1'b0;
        random_bcast        = 1'b0;
        rr_check            = 1'b0;
        // only station 0 is granted before the alternation, so class 1 leads it
        rr_next             = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        tick();
        check_flag("issue_valid after reset", issue_valid, 1'b0);
        check_flag("dispatch_stall after reset", dispatch_stall, 1'b0);

        // four alu instructions fill station 0 while the issue port is held off
        for (int i = 0; i < 4; i++) begin
            offer(1'b0, 1'b1);
            wait_taken();
        end
        offer(1'b0, 1'b1);
        hold = issued;
        repeat (6) tick();
        check_flag("dispatch_stall with a full station", dispatch_stall, 1'b1);
        if (issued != hold) begin
            errors++;
            $display("an instruction issued while issue_ready was low");
        end
        issue_ready = 1'b1;
        drain();

        // two ready entries go to each station before the port opens
        issue_ready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            offer(fu_class_t'(i % 2), 1'b1);
            wait_taken();
        end
        rr_check    = 1'b1;
        issue_ready = 1'b1;
        drain();
        rr_check = 1'b0;

        // random mix of classes, waiting sources, broadcasts and back-pressure
        random_ready = 1'b1;
        random_bcast = 1'b1;
        for (int i = 0; i < n_random; i++) begin
            offer(fu_class_t'($urandom_range(1)), 1'b0);
            wait_taken();
        end
        drain();

        if ((in_flight != '0) || (issued != accepted)) begin
            errors++;
            $display("accepted instructions were left without an issue");
        end
        $display("errors: %0d, accepted: %0d, issued: %0d", errors, accepted, issued);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rs_issue_stage.f ====
rtl/rs_pkg.sv
rtl/rs_dispatch_if.sv
rtl/rs_dispatch_router.sv
rtl/reservation_station.sv
rtl/rs_issue_arbiter.sv
rtl/rs_issue_stage.sv
bench/rs_issue_stage_props.sv
bench/rs_issue_stage_tb.sv

// ==== rtl/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station
    import rs_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    rs_dispatch_if.station disp,
    input  logic           cdb_valid,
    input  rob_tag_t       cdb_tag,
    input  word_t          cdb_value,
    output logic           req,
    output rs_entry_t      sel_entry,
    input  logic           grant
);

    // slot storage with a valid bit and an age beside each payload
    rs_entry_t                entries [station_depth];
    logic [station_depth-1:0] slot_valid;
    logic [age_w-1:0]         slot_age [station_depth];

    logic [station_depth-1:0] slot_ready;
    logic [slot_w-1:0]        free_idx;
    logic [slot_w-1:0]        sel_idx;
    logic                     sel_found;
    logic [count_w-1:0]       valid_count;
    logic [age_w-1:0]         new_age;

    // count the occupied slots and find the lowest free one
    // scanning downwards leaves the lowest free index in free_idx
    always_comb begin
        valid_count = '0;
        free_idx    = '0;
        for (int i = station_depth - 1; i >= 0; i--) begin
            if (slot_valid[i]) begin
                valid_count = valid_count + 1'b1;
            end else begin
                free_idx = slot_w'(i);
            end
        end
    end

    // an entry may issue once both of its sources hold values
    always_comb begin
        for (int i = 0; i < station_depth; i++) begin
            slot_ready[i] = slot_valid[i] && entries[i].src1_ready && entries[i].src2_ready;
        end
    end

    // pick the oldest ready entry
    // ages are unique among valid slots so the smallest age is the oldest instruction
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < station_depth; i++) begin
            if (slot_ready[i] && (!sel_found || (slot_age[i] < slot_age[sel_idx]))) begin
                sel_found = 1'b1;
                sel_idx   = slot_w'(i);
            end
        end
    end

    // the request is a level straight from the stored state
    // and the selected entry stays put until the arbiter grants it
    assign req       = sel_found;
    assign sel_entry = entries[sel_idx];

    assign disp.full = (valid_count == count_w'(station_depth));

    // a new entry is younger than every entry that stays past this edge
    // so an entry leaving on the same edge is not counted
    assign new_age = age_w'(valid_count - count_w'(grant));

    // slot occupancy and ages
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
            for (int i = 0; i < station_depth; i++) begin
                slot_age[i] <= '0;
            end
        end else begin
            // entries younger than the one leaving move one step up
            // which keeps the ages dense and the order exact
            if (grant) begin
                for (int i = 0; i < station_depth; i++) begin
                    if (slot_valid[i] && (slot_age[i] > slot_age[sel_idx])) begin
                        slot_age[i] <= slot_age[i] - 1'b1;
                    end
                end
                slot_valid[sel_idx] <= 1'b0;
            end
            // the router never writes while full, so free_idx points at an empty slot
            if (disp.valid) begin
                slot_valid[free_idx] <= 1'b1;
                slot_age[free_idx]   <= new_age;
            end
        end
    end

    // payload write and wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < station_depth; i++) begin
            if (slot_valid[i] && cdb_valid) begin
                // a waiting source whose producer tag is on the bus takes the value
                if (!entries[i].src1_ready && (entries[i].src1.pending.tag == cdb_tag)) begin
                    entries[i].src1.value <= cdb_value;
                    entries[i].src1_ready <= 1'b1;
                end
                if (!entries[i].src2_ready && (entries[i].src2.pending.tag == cdb_tag)) begin
                    entries[i].src2.value <= cdb_value;
                    entries[i].src2_ready <= 1'b1;
                end
            end
        end
        // the free slot is invalid, so the wakeup above never touches it
        if (disp.valid) begin
            entries[free_idx] <= disp.entry;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rs_dispatch_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// carries one dispatched entry from the router into a single reservation station
interface rs_dispatch_if
    import rs_pkg::*;
();

    // one-cycle write strobe, the station stores entry on every edge where it is high
    logic valid;

    // the assembled entry with any same-cycle broadcast already folded in
    rs_entry_t entry;

    // level from the station, high while every slot is occupied
    logic full;

    // the router only raises valid while full is low
    modport router (
        output valid,
        output entry,
        input  full
    );

    modport station (
        input  valid,
        input  entry,
        output full
    );

endinterface

`default_nettype wire

// ==== rtl/rs_dispatch_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_dispatch_router
    import rs_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatch_valid,
    input  fu_class_t            dispatch_class,
    input  alu_op_t              dispatch_op,
    input  rob_tag_t             dispatch_dest,
    input  operand_u             dispatch_src1,
    input  logic                 dispatch_src1_ready,
    input  operand_u             dispatch_src2,
    input  logic                 dispatch_src2_ready,
    input  logic                 cdb_valid,
    input  rob_tag_t             cdb_tag,
    input  word_t                cdb_value,
    output logic                 dispatch_stall,
    rs_dispatch_if.router        disp [num_stations]
);

    logic [num_stations-1:0] full_vec;
    logic                    src1_hit;
    logic                    src2_hit;
    rs_entry_t               entry;

    // a broadcast in the dispatch cycle would reach the station one edge too late
    // so a waiting source whose tag matches takes the value here instead
    assign src1_hit = cdb_valid && !dispatch_src1_ready && (dispatch_src1.pending.tag == cdb_tag);
    assign src2_hit = cdb_valid && !dispatch_src2_ready && (dispatch_src2.pending.tag == cdb_tag);

    always_comb begin
        entry.op         = dispatch_op;
        entry.dest       = dispatch_dest;
        entry.src1       = dispatch_src1;
        entry.src2       = dispatch_src2;
        entry.src1_ready = dispatch_src1_ready || src1_hit;
        entry.src2_ready = dispatch_src2_ready || src2_hit;
        // overwrite the tag view with the broadcast value
        if (src1_hit) begin
            entry.src1.value = cdb_value;
        end
        if (src2_hit) begin
            entry.src2.value = cdb_value;
        end
    end

    // every station sees the same entry, only the selected one gets the strobe
    for (genvar i = 0; i < num_stations; i++) begin : g_route
        assign full_vec[i]    = disp[i].full;
        assign disp[i].entry  = entry;
        assign disp[i].valid  = dispatch_valid && (dispatch_class == fu_class_t'(i)) &&
                                !full_vec[i];
    end

    // stall follows the full level of the station this instruction is aimed at
    assign dispatch_stall = full_vec[dispatch_class];

endmodule

`default_nettype wire

// ==== rtl/rs_issue_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_issue_arbiter
    import rs_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [num_stations-1:0] req,
    input  rs_entry_t               sel_entry [num_stations],
    input  logic                    issue_ready,
    output logic [num_stations-1:0] grant,
    output logic                    issue_valid,
    output fu_class_t               issue_class,
    output alu_op_t                 issue_op,
    output rob_tag_t                issue_dest,
    output word_t                   issue_a,
    output word_t                   issue_b
);

    // index of the station granted most recently
    logic [station_idx_w-1:0] last_grant;
    logic [station_idx_w-1:0] grant_idx;
    logic                     grant_any;
    logic                     grant_fire;

    // search starts just after the last winner and wraps around
    always_comb begin
        int cand;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int k = 1; k <= num_stations; k++) begin
            cand = (int'(last_grant) + k) % num_stations;
            if (!grant_any && req[cand]) begin
                grant_any = 1'b1;
                grant_idx = station_idx_w'(cand);
            end
        end
    end

    // back-pressure holds every grant off, the stations keep their entries
    assign grant_fire = issue_ready && grant_any;

    always_comb begin
        grant = '0;
        if (grant_fire) begin
            grant[grant_idx] = 1'b1;
        end
    end

    // issue_valid is a one-cycle pulse per granted entry
    // the pointer starts on the last station so station 0 wins first
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
            last_grant  <= station_idx_w'(num_stations - 1);
        end else begin
            issue_valid <= grant_fire;
            if (grant_fire) begin
                last_grant <= grant_idx;
            end
        end
    end

    // issue payload, sources are ready here so the value view applies
    always_ff @(posedge clk) begin
        if (grant_fire) begin
            issue_class <= fu_class_t'(grant_idx);
            issue_op    <= sel_entry[grant_idx].op;
            issue_dest  <= sel_entry[grant_idx].dest;
            issue_a     <= sel_entry[grant_idx].src1.value;
            issue_b     <= sel_entry[grant_idx].src2.value;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rs_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_issue_stage
    import rs_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dispatch_valid,
    input  fu_class_t dispatch_class,
    input  alu_op_t   dispatch_op,
    input  rob_tag_t  dispatch_dest,
    // a source word holds either the value or the producer tag in its low bits
    input  word_t     dispatch_src1,
    input  logic      dispatch_src1_ready,
    input  word_t     dispatch_src2,
    input  logic      dispatch_src2_ready,
    input  logic      cdb_valid,
    input  rob_tag_t  cdb_tag,
    input  word_t     cdb_value,
    input  logic      issue_ready,
    output logic      dispatch_stall,
    output logic      issue_valid,
    output fu_class_t issue_class,
    output alu_op_t   issue_op,
    output rob_tag_t  issue_dest,
    output word_t     issue_a,
    output word_t     issue_b
);

    // request and grant between the stations and the arbiter
    logic [num_stations-1:0] req;
    logic [num_stations-1:0] grant;
    rs_entry_t               sel_entry [num_stations];

    // one dispatch link per station
    rs_dispatch_if disp_if [num_stations] ();

    rs_dispatch_router rs_dispatch_router_inst (
        .clk                 (clk),
        .rst                 (rst),
        .dispatch_valid      (dispatch_valid),
        .dispatch_class      (dispatch_class),
        .dispatch_op         (dispatch_op),
        .dispatch_dest       (dispatch_dest),
        .dispatch_src1       (dispatch_src1),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src2       (dispatch_src2),
        .dispatch_src2_ready (dispatch_src2_ready),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .cdb_value           (cdb_value),
        .dispatch_stall      (dispatch_stall),
        .disp                (disp_if)
    );

    // station i serves functional unit class i
    for (genvar i = 0; i < num_stations; i++) begin : g_station
        reservation_station reservation_station_inst (
            .clk       (clk),
            .rst       (rst),
            .disp      (disp_if[i]),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .cdb_value (cdb_value),
            .req       (req[i]),
            .sel_entry (sel_entry[i]),
            .grant     (grant[i])
        );
    end

    rs_issue_arbiter rs_issue_arbiter_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .sel_entry   (sel_entry),
        .issue_ready (issue_ready),
        .grant       (grant),
        .issue_valid (issue_valid),
        .issue_class (issue_class),
        .issue_op    (issue_op),
        .issue_dest  (issue_dest),
        .issue_a     (issue_a),
        .issue_b     (issue_b)
    );

endmodule

`default_nettype wire

// ==== rtl/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

    // widths of the rv32i data path and of the reorder buffer tags
    localparam int xlen = 32;
    localparam int rob_tag_w = 3;

    // one station per functional unit class, class 0 is the alu and class 1 the multiplier
    localparam int num_stations = 2;
    localparam int station_depth = 4;

    // an entry's age counts the older entries still held in its station
    localparam int age_w = 2;

    // derived widths for slot indices, occupancy counts and station indices
    localparam int slot_w = $clog2(station_depth);
    localparam int count_w = $clog2(station_depth + 1);
    localparam int station_idx_w = (num_stations > 1) ? $clog2(num_stations) : 1;

    typedef logic [xlen-1:0] word_t;
    typedef logic [rob_tag_w-1:0] rob_tag_t;

    // selects the reservation station, and so the functional unit, of an instruction
    typedef logic fu_class_t;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        op_mul  = 4'd10,
        op_mulh = 4'd11
    } alu_op_t;

    // a source operand word, read as a value once ready and as the producer's tag before
    // the ready bit that travels beside it tells which of the two views is valid
    typedef union packed {
        word_t value;
        struct packed {
            logic [xlen-rob_tag_w-1:0] pad;
            rob_tag_t                  tag;
        } pending;
    } operand_u;

    // one renamed instruction as held in a station slot
    typedef struct packed {
        alu_op_t  op;
        rob_tag_t dest;
        operand_u src1;
        operand_u src2;
        logic     src1_ready;
        logic     src2_ready;
    } rs_entry_t;

endpackage

`default_nettype wire
